// File: Makefile
VERILATOR ?= verilator
TOP       ?= ioClkGenTb
FLIST     ?= ioClkGen.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASSMSG   ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: ioClkGen.f
rtl/ioClkGenPkg.sv
rtl/cfgQueueIf.sv
rtl/loadAlign.sv
rtl/configPort.sv
rtl/configQueue.sv
rtl/clkDivider.sv
rtl/ioClkGen.sv
verification/tbClkGen.sv
verification/ioClkGenChecker.sv
verification/ioClkGen_sva.sv
verification/ioClkGenTb.sv

// File: rtl/cfgQueueIf.sv
interface cfgQueueIf import ioClkGenPkg::*; ();

    // push side from the command port
    logic                    pushValid;
    logic                    pushReady;
    logic [cfgWordWidth-1:0] pushWord;

    // pop side into the divider
    logic                    popValid;
    logic                    popReady;
    logic [cfgWordWidth-1:0] popWord;

    modport writer (output pushValid, output pushWord, input pushReady);
    modport queue (input pushValid, input pushWord, input popReady,
                   output pushReady, output popValid, output popWord);
    modport reader (input popValid, input popWord, output popReady);

endinterface

// File: rtl/clkDivider.sv
module clkDivider import ioClkGenPkg::*; (
    input  logic                   divided_clk_src,
    input  logic                   rstN,
    input  logic                   clkEn,
    input  logic                   srcTick0,
    input  logic                   srcTick1,
    input  logic                   srcTick2,
    cfgQueueIf.reader              cfgQ,
    output logic                   dividedClk,
    output logic [clkSelWidth-1:0] dividedClkSel
);

    cfgWordT                 activeCfg;
    cfgWordT                 headCfg;
    logic [divisorWidth-1:0] divCount;
    logic                    selTick;
    logic                    tick;
    logic                    boundary;

    always_comb begin
        selTick = 1'b1;
        case (activeCfg.fields.clkSel)
            selSys:  selTick = 1'b1;
            selSrc0: selTick = srcTick0;
            selSrc1: selTick = srcTick1;
            selSrc2: selTick = srcTick2;
        endcase
    end

    assign tick = selTick && clkEn;
    assign boundary = tick && (divCount == activeCfg.fields.divisor);

    // new words are only taken at the end of a half period
    assign cfgQ.popReady = boundary;
    assign headCfg.raw = cfgQ.popWord;

    always_ff @(posedge divided_clk_src or negedge rstN) begin
        if (!rstN) begin
            activeCfg.raw <= '0;
            divCount <= '0;
            dividedClk <= 1'b0;
        end else if (boundary) begin
            divCount <= '0;
            dividedClk <= ~dividedClk;
            if (cfgQ.popValid) begin
                activeCfg <= headCfg;
            end
        end else if (tick) begin
            divCount <= divCount + 1'b1;
        end
    end

    assign dividedClkSel = activeCfg.fields.clkSel;

endmodule

// File: rtl/configPort.sv
module configPort import ioClkGenPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                    divided_clk_src,
    input  logic                    rstN,
    input  logic                    clkEn,
    input  logic                    cmdValid,
    input  logic                    loadEn,
    input  logic [3:0]              minorOpcode,
    input  logic [dataWidth-1:0]    dataAddrOffset,
    input  logic [cfgWordWidth-1:0] configWord,
    input  logic [3:0]              regDest,
    input  logic                    respReady,
    output logic                    cmdReady,
    output logic                    respValid,
    output logic [3:0]              respRegDest,
    output logic [dataWidth-1:0]    respData,
    cfgQueueIf.writer               cfgQ
);

    cfgWordT cfgReg;
    logic    writeFire;

    // reads wait on the requester, writes wait on queue space
    assign cmdReady = loadEn ? respReady : cfgQ.pushReady;
    assign respValid = cmdValid && loadEn;
    assign writeFire = cmdValid && cmdReady && !loadEn && clkEn;

    // incoming word goes straight into the queue on the accepting edge
    assign cfgQ.pushValid = cmdValid && !loadEn && clkEn;
    assign cfgQ.pushWord = configWord;

    always_ff @(posedge divided_clk_src or negedge rstN) begin
        if (!rstN) begin
            cfgReg.raw <= '0;
        end else if (writeFire) begin
            cfgReg.raw <= configWord;
        end
    end

    loadAlign #(
        .dataWidth(dataWidth)
    ) align_i (
        .minorOpcode(minorOpcode),
        .dataAddr   (dataAddrOffset),
        .dataIn     (dataWidth'(cfgReg.raw)),
        .dataOut    (respData)
    );

    assign respRegDest = regDest;

endmodule

// File: rtl/configQueue.sv
module configQueue import ioClkGenPkg::*; #(
    parameter int queueDepth = 4
) (
    input logic      divided_clk_src,
    input logic      rstN,
    input logic      clkEn,
    cfgQueueIf.queue cfgQ
);

    localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(queueDepth - 1);

    cfgWordT             mem [queueDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth:0]   count;
    logic                pushFire;
    logic                popFire;

    assign cfgQ.pushReady = (count != (ptrWidth + 1)'(queueDepth));
    assign cfgQ.popValid = (count != '0);
    assign cfgQ.popWord = mem[rdPtr].raw;

    assign pushFire = cfgQ.pushValid && cfgQ.pushReady && clkEn;
    assign popFire = cfgQ.popValid && cfgQ.popReady && clkEn;

    always_ff @(posedge divided_clk_src or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            for (int i = 0; i < queueDepth; i++) begin
                mem[i].raw <= '0;
            end
        end else begin
            if (pushFire) begin
                mem[wrPtr].raw <= cfgQ.pushWord;
                wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (popFire) begin
                rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            if (pushFire && !popFire) begin
                count <= count + 1'b1;
            end else if (popFire && !pushFire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/ioClkGen.sv
module ioClkGen import ioClkGenPkg::*; #(
    parameter int dataWidth = 16,
    parameter int queueDepth = 4
) (
    input  logic                    divided_clk_src,
    input  logic                    rstN,
    input  logic                    clkEn,
    input  logic                    srcTick0,
    input  logic                    srcTick1,
    input  logic                    srcTick2,
    input  logic                    cmdValid,
    input  logic                    loadEn,
    input  logic [3:0]              minorOpcode,
    input  logic [dataWidth-1:0]    dataAddrOffset,
    input  logic [cfgWordWidth-1:0] configWord,
    input  logic [3:0]              regDest,
    input  logic                    respReady,
    output logic                    cmdReady,
    output logic                    respValid,
    output logic [3:0]              respRegDest,
    output logic [dataWidth-1:0]    respData,
    output logic                    dividedClk,
    output logic [clkSelWidth-1:0]  dividedClkSel
);

    cfgQueueIf cfgQ ();

    configPort #(
        .dataWidth(dataWidth)
    ) port_i (
        .divided_clk_src(divided_clk_src),
        .rstN           (rstN),
        .clkEn          (clkEn),
        .cmdValid       (cmdValid),
        .loadEn         (loadEn),
        .minorOpcode    (minorOpcode),
        .dataAddrOffset (dataAddrOffset),
        .configWord     (configWord),
        .regDest        (regDest),
        .respReady      (respReady),
        .cmdReady       (cmdReady),
        .respValid      (respValid),
        .respRegDest    (respRegDest),
        .respData       (respData),
        .cfgQ           (cfgQ.writer)
    );

    configQueue #(
        .queueDepth(queueDepth)
    ) queue_i (
        .divided_clk_src(divided_clk_src),
        .rstN           (rstN),
        .clkEn          (clkEn),
        .cfgQ           (cfgQ.queue)
    );

    clkDivider divider_i (
        .divided_clk_src(divided_clk_src),
        .rstN           (rstN),
        .clkEn          (clkEn),
        .srcTick0       (srcTick0),
        .srcTick1       (srcTick1),
        .srcTick2       (srcTick2),
        .cfgQ           (cfgQ.reader),
        .dividedClk     (dividedClk),
        .dividedClkSel  (dividedClkSel)
    );

endmodule

// File: rtl/ioClkGenPkg.sv
package ioClkGenPkg;

    localparam int cfgWordWidth = 16;
    localparam int clkSelWidth = 2;
    localparam int divisorWidth = cfgWordWidth - clkSelWidth;

    // tick source on top, divisor below
    typedef struct packed {
        logic [clkSelWidth-1:0]  clkSel;
        logic [divisorWidth-1:0] divisor;
    } cfgFieldsT;

    typedef union packed {
        logic [cfgWordWidth-1:0] raw;
        cfgFieldsT               fields;
    } cfgWordT;

    // minor opcodes for i/o loads, anything else returns the whole word
    localparam logic [3:0] loadByteU = 4'b0000;
    localparam logic [3:0] loadHalfU = 4'b0001;
    localparam logic [3:0] loadByteS = 4'b0100;
    localparam logic [3:0] loadHalfS = 4'b0101;

    // tick source codes
    localparam logic [clkSelWidth-1:0] selSys = 2'd0;
    localparam logic [clkSelWidth-1:0] selSrc0 = 2'd1;
    localparam logic [clkSelWidth-1:0] selSrc1 = 2'd2;
    localparam logic [clkSelWidth-1:0] selSrc2 = 2'd3;

endpackage

// File: rtl/loadAlign.sv
module loadAlign import ioClkGenPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic [3:0]           minorOpcode,
    input  logic [dataWidth-1:0] dataAddr,
    input  logic [dataWidth-1:0] dataIn,
    output logic [dataWidth-1:0] dataOut
);

    logic [7:0]              byteSel;
    logic [cfgWordWidth-1:0] halfSel;

    // the port is two bytes wide, so only address bit 0 matters
    assign byteSel = dataAddr[0] ? dataIn[15:8] : dataIn[7:0];
    assign halfSel = dataIn[cfgWordWidth-1:0];

    always_comb begin
        case (minorOpcode)
            loadByteU: begin
                dataOut = dataWidth'(byteSel);
            end
            loadByteS: begin
                dataOut = dataWidth'($signed(byteSel));
            end
            loadHalfU: begin
                dataOut = dataWidth'(halfSel);
            end
            loadHalfS: begin
                dataOut = dataWidth'($signed(halfSel));
            end
            default: begin
                // full word
                dataOut = dataIn;
            end
        endcase
    end

endmodule

// File: verification/ioClkGenChecker.sv
module ioClkGenChecker import ioClkGenPkg::*; #(
    parameter int dataWidth = 16,
    parameter int queueDepth = 4
) (
    input logic                 clk,
    input logic                 rstN,
    input logic                 clkEn,
    input logic                 srcTick0,
    input logic                 srcTick1,
    input logic                 srcTick2,
    input logic                 cmdValid,
    input logic                 loadEn,
    input logic                 cmdReady,
    input logic [3:0]           minorOpcode,
    input logic [dataWidth-1:0] dataAddrOffset,
    input logic [15:0]          configWord,
    input logic [3:0]           regDest,
    input logic                 respReady,
    input logic                 respValid,
    input logic [3:0]           respRegDest,
    input logic [dataWidth-1:0] respData,
    input logic                 dividedClk,
    input logic [1:0]           dividedClkSel
);
    timeunit 1ns;
    timeprecision 100ps;

    int      errors = 0;
    string   testName = "reset";
    cfgWordT pending[$];
    cfgWordT active;
    cfgWordT shadow;
    cfgWordT pushWord;
    logic    pushPending;
    logic    prevClk;
    logic    expReady;
    int      tickCount;

    // expected aligned read data, built from the load rules
    function automatic logic [dataWidth-1:0] refLoad(input logic [3:0] op,
            input logic [dataWidth-1:0] addr, input logic [15:0] word);
        logic [7:0]           b;
        logic [dataWidth-1:0] r;
        b = addr[0] ? word[15:8] : word[7:0];
        case (op)
            loadByteU, loadByteS: begin
                r = (op == loadByteS && b[7]) ? '1 : '0;
                r[7:0] = b;
            end
            default: begin
                r = (op == loadHalfS && word[15]) ? '1 : '0;
                r[15:0] = word;
            end
        endcase
        return r;
    endfunction

    function automatic logic tickOf(input logic [1:0] sel);
        case (sel)
            selSrc0: return srcTick0;
            selSrc1: return srcTick1;
            selSrc2: return srcTick2;
            default: return 1'b1;
        endcase
    endfunction

    task automatic failValue(input string what, input longint exp, input longint act);
        errors++;
        $display("Fail %s: %s expected %0h actual %0h", testName, what, exp, act);
    endtask

    // outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        if (!rstN) begin
            pending.delete();
            active.raw = '0;
            shadow.raw = '0;
            pushPending = 1'b0;
            tickCount = 0;
            if (dividedClk !== 1'b0 || dividedClkSel !== 2'd0) begin
                failValue("output during reset", 0, {dividedClkSel, dividedClk});
            end
        end else begin
            if (dividedClk !== prevClk) begin
                if (tickCount != active.fields.divisor + 1) begin
                    failValue("half period ticks", active.fields.divisor + 1, tickCount);
                end
                tickCount = 0;
                if (pending.size() > 0) begin
                    active = pending.pop_front();
                end
            end
            // a word pushed on this edge was not visible to the pop
            if (pushPending) begin
                pending.push_back(pushWord);
                pushPending = 1'b0;
            end
            if (dividedClkSel !== active.fields.clkSel) begin
                failValue("dividedClkSel", active.fields.clkSel, dividedClkSel);
            end
            // reads follow respReady, writes wait for queue space
            expReady = loadEn ? respReady : (pending.size() < queueDepth);
            if (cmdReady !== expReady) begin
                failValue("cmdReady", expReady, cmdReady);
            end
            if (respValid !== (cmdValid && loadEn)) begin
                failValue("respValid", cmdValid && loadEn, respValid);
            end
            if (cmdValid && loadEn && respReady) begin
                if (respData !== refLoad(minorOpcode, dataAddrOffset, shadow.raw)) begin
                    failValue("respData", refLoad(minorOpcode, dataAddrOffset, shadow.raw),
                              respData);
                end
                if (respRegDest !== regDest) begin
                    failValue("respRegDest", regDest, respRegDest);
                end
            end
            if (cmdValid && !loadEn && cmdReady && clkEn) begin
                pushPending = 1'b1;
                pushWord.raw = configWord;
                shadow.raw = configWord;
            end
            if (clkEn && tickOf(active.fields.clkSel)) begin
                tickCount++;
            end
        end
        prevClk = dividedClk;
    end

endmodule

// File: verification/ioClkGenTb.sv
module ioClkGenTb import ioClkGenPkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int dataWidth = 32;
    localparam int queueDepth = 4;
    // half periods summed over all tests, and the slowest one in cycles
    localparam int totalHalves = 90;
    localparam int maxHalfCycles = 4 * 128;
    localparam int watchdogNs = totalHalves * maxHalfCycles * 10 + 20000;

    logic clk, rstN, clkEn, srcTick0, srcTick1, srcTick2;
    logic cmdValid, loadEn, respReady, cmdReady, respValid, dividedClk;
    logic [3:0] minorOpcode, regDest, respRegDest;
    logic [dataWidth-1:0] dataAddrOffset, respData;
    logic [15:0] configWord;
    logic [1:0] dividedClkSel;

    logic [31:0] lfsr = 32'he9eb4f07;
    logic gapsOn = 1'b0;
    logic stallsOn = 1'b0;
    logic holdLow = 1'b0;
    int stallCycles = 0;
    int tbErrors = 0;

    tbClkGen clkGen_i (.clk(clk), .rstN(rstN));

    ioClkGen #(.dataWidth(dataWidth), .queueDepth(queueDepth)) dut_i (
        .divided_clk_src(clk), .rstN(rstN), .clkEn(clkEn),
        .srcTick0(srcTick0), .srcTick1(srcTick1), .srcTick2(srcTick2),
        .cmdValid(cmdValid), .loadEn(loadEn), .minorOpcode(minorOpcode),
        .dataAddrOffset(dataAddrOffset), .configWord(configWord), .regDest(regDest),
        .respReady(respReady), .cmdReady(cmdReady), .respValid(respValid),
        .respRegDest(respRegDest), .respData(respData),
        .dividedClk(dividedClk), .dividedClkSel(dividedClkSel)
    );

    ioClkGenChecker #(.dataWidth(dataWidth), .queueDepth(queueDepth)) check_i (.*);

    // galois lfsr, one step per bit
    function automatic logic randBit();
        logic b;
        b = lfsr[0];
        lfsr = b ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return b;
    endfunction

    always @(posedge clk) begin
        srcTick0 <= randBit();
        srcTick1 <= randBit();
        srcTick2 <= randBit();
        if (!holdLow) begin
            clkEn <= gapsOn ? (randBit() | randBit()) : 1'b1;
        end else begin
            clkEn <= 1'b0;
        end
        respReady <= stallsOn ? randBit() : 1'b1;
    end

    task automatic startTest(input string name, input logic gaps, input logic stalls);
        @(negedge clk);
        check_i.testName = name;
        gapsOn = gaps;
        stallsOn = stalls;
    endtask

    task automatic writeWord(input logic [1:0] sel, input logic [13:0] div);
        @(posedge clk);
        cmdValid <= 1'b1;
        loadEn <= 1'b0;
        configWord <= {sel, div};
        do begin
            @(posedge clk);
            if (!cmdReady) begin
                stallCycles++;
            end
        end while (!(cmdReady && clkEn));
        cmdValid <= 1'b0;
    endtask

    // write held up for a fixed number of cycles and then dropped
    task automatic offerWrite(input logic [15:0] word, input int cycles);
        @(posedge clk);
        cmdValid <= 1'b1;
        loadEn <= 1'b0;
        configWord <= word;
        repeat (cycles) @(posedge clk);
        cmdValid <= 1'b0;
    endtask

    task automatic readWord(input logic [3:0] op, input logic offset);
        @(posedge clk);
        cmdValid <= 1'b1;
        loadEn <= 1'b1;
        minorOpcode <= op;
        dataAddrOffset <= dataWidth'(offset);
        regDest <= regDest + 4'd1;
        do begin
            @(posedge clk);
        end while (!cmdReady);
        cmdValid <= 1'b0;
    endtask

    task automatic waitHalves(input int n);
        repeat (n) @(dividedClk);
    endtask

    initial begin
        logic [3:0] ops [5];
        logic [15:0] words [3];
        ops = '{loadByteU, loadByteS, loadHalfU, loadHalfS, 4'b1010};
        words = '{16'h807f, 16'h0080, 16'hc001};
        clkEn = 1'b1;
        {srcTick0, srcTick1, srcTick2} = 3'b000;
        {cmdValid, loadEn, respReady} = 3'b001;
        minorOpcode = '0;
        regDest = '0;
        dataAddrOffset = '0;
        configWord = '0;
        fork
            begin
                #(watchdogNs);
                $display("timeout: the run did not finish in %0d ns", watchdogNs);
                $display("RESULT: FAIL");
                $finish;
            end
        join_none

        @(posedge rstN);
        repeat (20) @(posedge clk);

        startTest("readback", 1'b0, 1'b1);
        foreach (words[w]) begin
            writeWord(words[w][15:14], words[w][13:0]);
            foreach (ops[o]) begin
                readWord(ops[o], 1'b0);
                readWord(ops[o], 1'b1);
            end
        end

        startTest("divide sys", 1'b1, 1'b0);
        writeWord(selSys, 14'd3);
        writeWord(selSys, 14'd7);
        waitHalves(14);

        startTest("source select", 1'b1, 1'b0);
        writeWord(selSrc0, 14'd2);
        writeWord(selSrc1, 14'd4);
        writeWord(selSrc2, 14'd1);
        waitHalves(12);

        startTest("queue order", 1'b1, 1'b0);
        stallCycles = 0;
        writeWord(selSys, 14'd30);
        for (int i = 0; i < 6; i++) begin
            writeWord(2'(i), 14'(2 + i));
        end
        if (stallCycles == 0) begin
            tbErrors++;
            $display("Fail queue order: cmdReady never went low with the queue full");
        end
        waitHalves(14);

        startTest("hold", 1'b0, 1'b0);
        holdLow = 1'b1;
        @(posedge clk);
        // a write seen only while disabled must not reach the register
        offerWrite({selSrc2, 14'd9}, 8);
        readWord(loadHalfU, 1'b0);
        @(negedge clk);
        holdLow = 1'b0;
        writeWord(selSys, 14'd5);
        waitHalves(6);

        repeat (4) @(posedge clk);
        $display("errors: %0d", check_i.errors + tbErrors);
        if (check_i.errors + tbErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/ioClkGen_sva.sv
module ioClkGen_sva (
    input logic       divided_clk_src,
    input logic       rstN,
    input logic       clkEn,
    input logic       cmdValid,
    input logic       loadEn,
    input logic       pushReady,
    input logic       popReady,
    input logic       dividedClk,
    input logic [1:0] dividedClkSel
);
    timeunit 1ns;
    timeprecision 100ps;

    resetState: assert property (@(posedge divided_clk_src)
        !rstN |-> (!dividedClk && dividedClkSel == 2'd0))
        else $error("divided clock outputs not cleared in reset");

    // a write offered to a full queue leaves it full
    noWriteWhenFull: assert property (@(posedge divided_clk_src) disable iff (!rstN)
        (cmdValid && !loadEn && !pushReady && !(popReady && clkEn)) |=> !pushReady)
        else $error("write accepted while the queue is full");

    // nothing toggles across a disabled cycle
    holdOnDisable: assert property (@(posedge divided_clk_src) disable iff (!rstN)
        !clkEn |=> $stable(dividedClk))
        else $error("divided clock changed while clkEn was low");

endmodule

bind ioClkGen ioClkGen_sva sva_i (
    .divided_clk_src(divided_clk_src),
    .rstN           (rstN),
    .clkEn          (clkEn),
    .cmdValid       (cmdValid),
    .loadEn         (loadEn),
    .pushReady      (cfgQ.pushReady),
    .popReady       (cfgQ.popReady),
    .dividedClk     (dividedClk),
    .dividedClkSel  (dividedClkSel)
);

// File: verification/tbClkGen.sv
module tbClkGen #(
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule
